// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = float_core_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/alu.sv ====
module alu (
  input  core_pkg::word_t   a,
  input  core_pkg::word_t   b,
  input  core_pkg::opcode_t op,
  output core_pkg::word_t   alu_result
);

  core_pkg::word_t fmul_out;

  fp_multiply u_fp_multiply (
    .a       (a),
    .b       (b),
    .product (fmul_out)
  );

  always_comb
  begin
    case (op)
      core_pkg::OP_FMUL:
        alu_result = fmul_out;
      core_pkg::OP_AND:
        alu_result = a & b;
      core_pkg::OP_OR:
        alu_result = a | b;
      core_pkg::OP_XOR:
        alu_result = a ^ b;
      core_pkg::OP_GT:
        alu_result = (a > b) ? 32'd1 : 32'd0;  // Unsigned compare
      core_pkg::OP_LT:
        alu_result = (a < b) ? 32'd1 : 32'd0;
      core_pkg::OP_PASS:
        alu_result = a;
      default:
        alu_result = '0;
    endcase
  end

endmodule

// ==== hw/core_pkg.sv ====
package core_pkg;

  typedef logic [31:0] word_t;      // Data or instruction word
  typedef logic [4:0]  addr_t;      // Program memory address
  typedef logic [2:0]  reg_idx_t;   // Register bank index
  typedef logic [3:0]  opcode_t;    // Instruction opcode
  typedef logic [1:0]  port_sel_t;  // Bit 0 for r0, bit 1 for r1

  localparam int PROG_DEPTH = 32;
  localparam int NUM_REGS   = 8;

  // Top bit of each instruction field
  localparam int OP_MSB = 31;
  localparam int RS_MSB = 27;
  localparam int RA_MSB = 24;
  localparam int RB_MSB = 21;

  localparam opcode_t OP_NOP_ADD = 4'b0000;  // Retired add
  localparam opcode_t OP_NOP_SUB = 4'b0001;  // Retired subtract
  localparam opcode_t OP_FMUL    = 4'b0010;
  localparam opcode_t OP_AND     = 4'b0011;
  localparam opcode_t OP_OR      = 4'b0100;
  localparam opcode_t OP_XOR     = 4'b0101;
  localparam opcode_t OP_GT      = 4'b0110;
  localparam opcode_t OP_LT      = 4'b0111;
  localparam opcode_t OP_PASS    = 4'b1001;

  // Single-precision layout
  localparam int EXP_W    = 8;
  localparam int MAN_W    = 23;
  localparam int EXP_BIAS = 127;

endpackage

// ==== hw/float_core_top.sv ====
module float_core_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                run,
  input  logic                prog_we,
  input  core_pkg::word_t     prog_data,
  input  core_pkg::port_sel_t p_sel,
  input  core_pkg::word_t     P0,
  input  core_pkg::word_t     P1,
  output core_pkg::word_t     P0_out,
  output core_pkg::word_t     P1_out,
  output core_pkg::word_t     result,
  output logic                result_valid
);

  core_pkg::addr_t    pc;
  core_pkg::word_t    instr;
  core_pkg::opcode_t  op;
  core_pkg::reg_idx_t rs;
  core_pkg::reg_idx_t ra;
  core_pkg::reg_idx_t rb;
  core_pkg::word_t    operand_a;
  core_pkg::word_t    operand_b;

  pc_sequencer u_pc_sequencer (
    .clk     (clk),
    .reset   (reset),
    .run     (run),
    .prog_we (prog_we),
    .pc      (pc)
  );

  program_mem u_program_mem (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_data (prog_data),
    .pc        (pc),
    .instr     (instr)
  );

  // Write enable doubles as the result strobe
  instr_decode u_instr_decode (
    .clk   (clk),
    .reset (reset),
    .instr (instr),
    .op    (op),
    .rs    (rs),
    .ra    (ra),
    .rb    (rb),
    .wr_en (result_valid)
  );

  alu u_alu (
    .a          (operand_a),
    .b          (operand_b),
    .op         (op),
    .alu_result (result)
  );

  reg_bank u_reg_bank (
    .clk        (clk),
    .reset      (reset),
    .wr_en      (result_valid),
    .rs         (rs),
    .ra         (ra),
    .rb         (rb),
    .alu_result (result),
    .p_sel      (p_sel),
    .P0         (P0),
    .P1         (P1),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .P0_out     (P0_out),
    .P1_out     (P1_out)
  );

endmodule

// ==== hw/fp_multiply.sv ====
module fp_multiply (
  input  core_pkg::word_t a,
  input  core_pkg::word_t b,
  output core_pkg::word_t product
);

  localparam int EW = core_pkg::EXP_W;
  localparam int MW = core_pkg::MAN_W;
  localparam int SW = MW + 1;  // Significand with hidden bit

  logic            sign;
  logic [EW-1:0]   exp_a;
  logic [EW-1:0]   exp_b;
  logic            exception;
  logic [SW-1:0]   sig_a;
  logic [SW-1:0]   sig_b;
  logic [2*SW-1:0] raw;
  logic            normalised;
  logic [2*SW-1:0] norm;
  logic            sticky;
  logic [MW-1:0]   mantissa;
  logic [EW:0]     exponent;
  logic            overflow;
  logic            underflow;

  assign sign      = a[EW+MW] ^ b[EW+MW];
  assign exp_a     = a[MW +: EW];
  assign exp_b     = b[MW +: EW];
  assign exception = (&exp_a) | (&exp_b);  // Inf or NaN operand

  assign sig_a = {|exp_a, a[MW-1:0]};  // Hidden bit clear for denormals
  assign sig_b = {|exp_b, b[MW-1:0]};
  assign raw   = {{SW{1'b0}}, sig_a} * {{SW{1'b0}}, sig_b};

  assign normalised = raw[2*SW-1];
  assign norm       = normalised ? raw : raw << 1;
  assign sticky     = |norm[MW-1:0];
  assign mantissa   = norm[2*SW-2 -: MW] + MW'(norm[MW] & sticky);  // Round on bit 23

  // Nine-bit exponent whose top two bits flag out of range
  assign exponent  = {1'b0, exp_a} + {1'b0, exp_b} - (EW+1)'(core_pkg::EXP_BIAS)
                     + (EW+1)'(normalised);
  assign overflow  = exponent[EW] & ~exponent[EW-1];
  assign underflow = exponent[EW] & exponent[EW-1];

  always_comb
  begin
    if (exception)
      product = '0;
    else if (mantissa == '0)
      product = {sign, {(EW+MW){1'b0}}};  // Signed zero
    else if (overflow)
      product = {sign, {EW{1'b1}}, {MW{1'b0}}};  // Signed infinity
    else if (underflow)
      product = {sign, {(EW+MW){1'b0}}};
    else
      product = {sign, exponent[EW-1:0], mantissa};
  end

endmodule

// ==== hw/instr_decode.sv ====
module instr_decode (
  input  logic               clk,
  input  logic               reset,
  input  core_pkg::word_t    instr,
  output core_pkg::opcode_t  op,
  output core_pkg::reg_idx_t rs,
  output core_pkg::reg_idx_t ra,
  output core_pkg::reg_idx_t rb,
  output logic               wr_en
);

  core_pkg::word_t ir;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ir <= '0;  // Decodes as a no-op
    else
      ir <= instr;
  end

  assign op = ir[core_pkg::OP_MSB -: 4];
  assign rs = ir[core_pkg::RS_MSB -: 3];
  assign ra = ir[core_pkg::RA_MSB -: 3];
  assign rb = ir[core_pkg::RB_MSB -: 3];

  always_comb
  begin
    case (op)
      core_pkg::OP_NOP_ADD,
      core_pkg::OP_NOP_SUB: wr_en = 1'b0;  // Retired FP add and subtract
      core_pkg::OP_FMUL,
      core_pkg::OP_AND,
      core_pkg::OP_OR,
      core_pkg::OP_XOR,
      core_pkg::OP_GT,
      core_pkg::OP_LT,
      core_pkg::OP_PASS:    wr_en = 1'b1;
      default:              wr_en = 1'b0;
    endcase
  end

endmodule

// ==== hw/pc_sequencer.sv ====
module pc_sequencer (
  input  logic            clk,
  input  logic            reset,
  input  logic            run,
  input  logic            prog_we,
  output core_pkg::addr_t pc
);

  logic step;

  assign step = run | prog_we;  // Loading also walks the address

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc <= '0;
    end
    else if (step)
    begin
      if (pc == core_pkg::addr_t'(core_pkg::PROG_DEPTH - 1))
        pc <= '0;  // Wrap at end of program
      else
        pc <= pc + 5'd1;
    end
  end

endmodule

// ==== hw/program_mem.sv ====
module program_mem (
  input  logic            clk,
  input  logic            reset,
  input  logic            prog_we,
  input  core_pkg::word_t prog_data,
  input  core_pkg::addr_t pc,
  output core_pkg::word_t instr
);

  core_pkg::word_t mem [core_pkg::PROG_DEPTH];
  core_pkg::addr_t rd_addr;

  // Contents survive reset
  always_ff @(posedge clk)
  begin
    if (prog_we)
      mem[pc] <= prog_data;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      rd_addr <= '0;
    else
      rd_addr <= pc;  // Registered read address
  end

  assign instr = mem[rd_addr];

endmodule

// ==== hw/reg_bank.sv ====
module reg_bank (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wr_en,
  input  core_pkg::reg_idx_t   rs,
  input  core_pkg::reg_idx_t   ra,
  input  core_pkg::reg_idx_t   rb,
  input  core_pkg::word_t      alu_result,
  input  core_pkg::port_sel_t  p_sel,
  input  core_pkg::word_t      P0,
  input  core_pkg::word_t      P1,
  output core_pkg::word_t      operand_a,
  output core_pkg::word_t      operand_b,
  output core_pkg::word_t      P0_out,
  output core_pkg::word_t      P1_out
);

  core_pkg::word_t regs [core_pkg::NUM_REGS];
  core_pkg::word_t wr_data;

  // r0 and r1 load from the ports unless their select bit is set
  always_comb
  begin
    case (rs)
      3'd0:
        wr_data = p_sel[0] ? alu_result : P0;
      3'd1:
        wr_data = p_sel[1] ? alu_result : P1;
      default:
        wr_data = alu_result;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
    begin
      regs[rs] <= wr_data;
    end
  end

  assign operand_a = regs[ra];  // Same-cycle read of write-back target
  assign operand_b = regs[rb];

  assign P0_out = regs[0];
  assign P1_out = regs[1];

endmodule

// ==== src.f ====
hw/core_pkg.sv
hw/pc_sequencer.sv
hw/program_mem.sv
hw/instr_decode.sv
hw/fp_multiply.sv
hw/alu.sv
hw/reg_bank.sv
hw/float_core_top.sv
testbench/float_core_tb.sv

// ==== testbench/float_core_tb.sv ====
module float_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          PULSE_TIMEOUT = 64;  // Cycles allowed per result_valid wait
  localparam int          PASS_WINDOW   = 30;  // Stays inside the first program pass
  localparam logic [31:0] LFSR_TAPS     = 32'ha3000000;

  typedef struct packed {
    core_pkg::opcode_t op;
    core_pkg::word_t   a;
    core_pkg::word_t   b;
    core_pkg::word_t   expected;
    logic              random_ops;  // Operands drawn from the LFSR
    logic              writes;
    logic              to_r1;       // Word 4 targets r1 with p_sel bit 1 high
  } test_case_t;

  logic                clk;
  logic                reset;
  logic                run;
  logic                prog_we;
  core_pkg::word_t     prog_data;
  core_pkg::port_sel_t p_sel;
  core_pkg::word_t     P0;
  core_pkg::word_t     P1;
  core_pkg::word_t     P0_out;
  core_pkg::word_t     P1_out;
  core_pkg::word_t     result;
  logic                result_valid;

  test_case_t      cases [20];
  int              num_cases;
  core_pkg::word_t prog_words [core_pkg::PROG_DEPTH];
  logic [31:0]     lfsr_state;

  float_core_top u_float_core_top (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .prog_we      (prog_we),
    .prog_data    (prog_data),
    .p_sel        (p_sel),
    .P0           (P0),
    .P1           (P1),
    .P0_out       (P0_out),
    .P1_out       (P1_out),
    .result       (result),
    .result_valid (result_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_word(input string what, input core_pkg::word_t got,
                            input core_pkg::word_t exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %0t: %s is %08h, expected %08h", $time, what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("FAIL %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ({1'b0, s[31:1]} ^ LFSR_TAPS) : {1'b0, s[31:1]};
  endfunction

  task automatic random_word(output core_pkg::word_t w);
    w = '0;
    for (int i = 0; i < 32; i++)
    begin
      w = {w[30:0], lfsr_state[0]};  // One step per bit taken
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Integer ALU rules
  function automatic core_pkg::word_t logic_expected(input core_pkg::opcode_t op,
                                                     input core_pkg::word_t a,
                                                     input core_pkg::word_t b);
    logic [32:0] diff;  // Borrow out flags a below b
    diff = {1'b0, a} - {1'b0, b};
    case (op)
      core_pkg::OP_AND: return a & b;
      core_pkg::OP_OR:  return a | b;
      core_pkg::OP_XOR: return a ^ b;
      core_pkg::OP_GT:  return {31'd0, ~diff[32] & (|diff[31:0])};
      core_pkg::OP_LT:  return {31'd0, diff[32]};
      default:          return '0;
    endcase
  endfunction

  function automatic core_pkg::word_t encode(input core_pkg::opcode_t op,
                                             input core_pkg::reg_idx_t rs,
                                             input core_pkg::reg_idx_t ra,
                                             input core_pkg::reg_idx_t rb);
    return {op, rs, ra, rb, 19'd0};
  endfunction

  task automatic add_case(input core_pkg::opcode_t op, input core_pkg::word_t a,
                          input core_pkg::word_t b, input core_pkg::word_t exp,
                          input logic rnd, input logic wr, input logic r1);
    cases[num_cases] = '{op, a, b, exp, rnd, wr, r1};
    num_cases++;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #2;
    reset   = 1'b1;
    run     = 1'b0;
    prog_we = 1'b0;
    p_sel   = 2'b00;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
  endtask

  // Each write lands at the current pc, which then steps
  task automatic load_program();
    for (int i = 0; i < core_pkg::PROG_DEPTH; i++)
    begin
      @(posedge clk);
      #2;
      prog_we   = 1'b1;
      prog_data = prog_words[i];
    end
    @(posedge clk);
    #2;
    prog_we = 1'b0;
  endtask

  task automatic wait_pulse(input string what, output core_pkg::word_t value);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    value  = '0;
    while (!seen && cycles < PULSE_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      if (result_valid === 1'b1)
      begin
        seen  = 1'b1;
        value = result;
      end
    end
    if (!seen)
      abort_run($sformatf("Timed out waiting for the result_valid pulse of %s", what));
  endtask

  task automatic run_case(input test_case_t tc);
    core_pkg::word_t p0;
    core_pkg::word_t p1;
    core_pkg::word_t expect_val;
    core_pkg::word_t value;
    int              pulses;
    p0         = tc.a;
    p1         = tc.b;
    expect_val = tc.expected;
    if (tc.random_ops)
    begin
      random_word(p0);
      random_word(p1);
      expect_val = logic_expected(tc.op, p0, p1);
    end
    foreach (prog_words[i])
      prog_words[i] = '0;  // Word 0 stays a no-op so the idle pipeline writes nothing
    prog_words[1] = encode(core_pkg::OP_PASS, 3'd0, 3'd0, 3'd0);  // r0 from P0
    prog_words[2] = encode(core_pkg::OP_PASS, 3'd2, 3'd0, 3'd0);  // r2 from r0
    prog_words[3] = encode(core_pkg::OP_PASS, 3'd1, 3'd1, 3'd0);  // r1 from P1
    prog_words[4] = encode(tc.op, tc.to_r1 ? 3'd1 : 3'd3, 3'd2, 3'd1);
    apply_reset();
    load_program();
    apply_reset();
    @(posedge clk);
    #2;
    P0 = p0;
    P1 = p1;
    repeat (4)
    begin
      @(negedge clk);
      check_bit("idle result_valid", result_valid, 1'b0);
      check_word("idle P0_out", P0_out, '0);
      check_word("idle P1_out", P1_out, '0);
    end
    @(posedge clk);
    #2;
    run = 1'b1;
    if (!tc.writes)
    begin
      pulses = 0;
      repeat (PASS_WINDOW)
      begin
        @(negedge clk);
        if (result_valid === 1'b1)
          pulses++;
      end
      check_word("result_valid pulse count", core_pkg::word_t'(pulses), 32'd3);
      check_word("P0_out", P0_out, p0);
      check_word("P1_out", P1_out, p1);
    end
    else
    begin
      wait_pulse("word 1", value);
      check_word("pass of cleared r0", value, '0);
      wait_pulse("word 2", value);
      check_word("pass of r0", value, p0);
      wait_pulse("word 3", value);
      check_word("pass of cleared r1", value, '0);
      if (tc.to_r1)
      begin
        @(posedge clk);
        #2;
        p_sel = 2'b10;  // Between the r1 port load and the word 4 write
      end
      wait_pulse("word 4", value);
      check_word("ALU result", value, expect_val);
      @(posedge clk);
      #2;
      check_word("P0_out", P0_out, p0);
      check_word("P1_out", P1_out, tc.to_r1 ? expect_val : p1);
    end
  endtask

  initial
  begin
    reset      = 1'b1;
    run        = 1'b0;
    prog_we    = 1'b0;
    prog_data  = '0;
    p_sel      = 2'b00;
    P0         = '0;
    P1         = '0;
    lfsr_state = 32'h13b4;
    num_cases  = 0;
    add_case(core_pkg::OP_FMUL, 32'h40000000, 32'h3fc00000, 32'h40400000, 1'b0, 1'b1, 1'b0);
    add_case(core_pkg::OP_FMUL, 32'hc0000000, 32'h3fc00000, 32'hc0400000, 1'b0, 1'b1, 1'b0);
    add_case(core_pkg::OP_FMUL, 32'h3fc00000, 32'h3fc00000, 32'h40100000, 1'b0, 1'b1, 1'b0);
    add_case(core_pkg::OP_FMUL, 32'h00000000, 32'hbfc00000, 32'h80000000, 1'b0, 1'b1, 1'b0);
    add_case(core_pkg::OP_FMUL, 32'h7f800000, 32'h40000000, 32'h00000000, 1'b0, 1'b1, 1'b0);
    add_case(core_pkg::OP_FMUL, 32'hff400000, 32'h7f400000, 32'hff800000, 1'b0, 1'b1, 1'b0);
    add_case(core_pkg::OP_FMUL, 32'h8dc00000, 32'h0dc00000, 32'h80000000, 1'b0, 1'b1, 1'b0);
    add_case(core_pkg::OP_AND,  '0, '0, '0, 1'b1, 1'b1, 1'b0);
    add_case(core_pkg::OP_OR,   '0, '0, '0, 1'b1, 1'b1, 1'b0);
    add_case(core_pkg::OP_XOR,  '0, '0, '0, 1'b1, 1'b1, 1'b0);
    add_case(core_pkg::OP_GT,   '0, '0, '0, 1'b1, 1'b1, 1'b0);
    add_case(core_pkg::OP_LT,   '0, '0, '0, 1'b1, 1'b1, 1'b0);
    add_case(core_pkg::OP_NOP_ADD, 32'h40000000, 32'h3fc00000, '0, 1'b0, 1'b0, 1'b0);
    add_case(core_pkg::OP_NOP_SUB, 32'h40000000, 32'h3fc00000, '0, 1'b0, 1'b0, 1'b0);
    add_case(4'b1000, 32'h40000000, 32'h3fc00000, '0, 1'b0, 1'b0, 1'b0);
    add_case(core_pkg::OP_FMUL, 32'h40000000, 32'h3fc00000, 32'h40400000, 1'b0, 1'b1, 1'b1);
    for (int i = 0; i < num_cases; i++)
      run_case(cases[i]);
    $display("TEST PASSED");
    $finish;
  end

endmodule
